// ==== hw/alu_exec.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu_exec (
	input logic reset,
	decode_if.execute dec,
	input logic [`CPU_DATA_W-1:0] x,
	input logic [`CPU_DATA_W-1:0] y,
	input logic [`CPU_DATA_W-1:0] z,
	input cpu_pkg::flags_t flags,
	exec_result_if.execute res
);
	logic [`CPU_DATA_W-1:0] acc;
	logic [`CPU_DATA_W-1:0] result;
	logic carry;
	logic word_op;
	logic zero;
	logic neg;

	// accumulator is whatever register the op targets
	always_comb
	begin
		case (dec.dst)
			cpu_pkg::REG_Y: acc = y;
			cpu_pkg::REG_Z: acc = z;
			default: acc = x;
		endcase
	end

	always_comb
	begin
		result = acc;
		carry = flags.c;
		case (dec.alu_op)
			cpu_pkg::PASS_IMM: result = dec.imm;
			cpu_pkg::ADD: {carry, result[7:0]} = {1'b0, acc[7:0]} + {1'b0, dec.imm[7:0]};
			// bit 8 of the difference is the borrow
			cpu_pkg::SUB: {carry, result[7:0]} = {1'b0, acc[7:0]} - {1'b0, dec.imm[7:0]};
			cpu_pkg::AND: result[7:0] = acc[7:0] & dec.imm[7:0];
			cpu_pkg::OR: result[7:0] = acc[7:0] | dec.imm[7:0];
			cpu_pkg::XOR: result[7:0] = acc[7:0] ^ dec.imm[7:0];
			cpu_pkg::PASS_Y: result = y;
			cpu_pkg::ADDW: {carry, result} = {1'b0, acc} + {1'b0, x};
			default: result = acc;
		endcase
	end

	assign word_op = (dec.alu_op == cpu_pkg::ADDW);
	assign zero = word_op ? (result == '0) : (result[7:0] == 8'h00);
	assign neg = word_op ? result[`CPU_DATA_W-1] : result[7];

	assign res.next_flags.c = dec.flag_upd.c ? carry : flags.c;
	assign res.next_flags.z = dec.flag_upd.z ? zero : flags.z;
	assign res.next_flags.n = dec.flag_upd.n ? neg : flags.n;

	assign res.result = result;
	assign res.dst = dec.dst;
	assign res.wr_en = reset ? 2'b00 : dec.wr_en;

	// direct address from the immediate word
	assign res.st_en = reset ? 2'b00 : dec.store_en;
	assign res.st_addr = dec.imm;
	assign res.st_data = dec.store_en[1] ? y : x;
endmodule

// ==== hw/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// register, data and address width
`define CPU_DATA_W 16

// one fetched instruction word, opcode in the low byte
`define CPU_INSN_W 24

// x, y and z
`define CPU_NUM_REGS 3

// first fetch address after reset
`define CPU_RESET_PC 16'h4000

`endif

// ==== hw/cpu_ifs.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

// control fields of the instruction in flight
interface decode_if;
	cpu_pkg::alu_op_t alu_op;
	logic [`CPU_DATA_W-1:0] imm;
	cpu_pkg::reg_sel_t dst;
	logic [1:0] wr_en;
	cpu_pkg::flags_t flag_upd;
	cpu_pkg::branch_t branch;
	logic [1:0] length;
	logic [1:0] store_en;
	logic halt;

	modport decoder (output alu_op, imm, dst, wr_en, flag_upd, branch, length, store_en, halt);
	modport execute (input alu_op, imm, dst, wr_en, flag_upd, store_en);
	modport sequencer (input imm, branch, length, halt);
endinterface

// what the execute stage commits at the next edge
interface exec_result_if;
	logic [`CPU_DATA_W-1:0] result;
	cpu_pkg::reg_sel_t dst;
	logic [1:0] wr_en;
	cpu_pkg::flags_t next_flags;
	logic [1:0] st_en;
	logic [`CPU_DATA_W-1:0] st_addr;
	logic [`CPU_DATA_W-1:0] st_data;

	modport execute (output result, dst, wr_en, next_flags, st_en, st_addr, st_data);
	modport writeback (input result, dst, wr_en, next_flags, st_en, st_addr, st_data);
endinterface

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	typedef enum logic [7:0] {
		NOP         = 8'h00,
		LD_XL_IMMD  = 8'h01,
		ADD_XL_IMMD = 8'h02,
		SUB_XL_IMMD = 8'h03,
		AND_XL_IMMD = 8'h04,
		OR_XL_IMMD  = 8'h05,
		XOR_XL_IMMD = 8'h06,
		CP_XL_IMMD  = 8'h07,
		LDW_Y_IMMD  = 8'h08,
		LDW_X_Y     = 8'h09,
		LDW_Z_Y     = 8'h0A,
		ADDW_Y_X    = 8'h0B,
		JR_D        = 8'h0C,
		JRZ_D       = 8'h0D,
		JRNZ_D      = 8'h0E,
		JRC_D       = 8'h0F,
		LD_DIR_XL   = 8'h10,
		LDW_DIR_Y   = 8'h11,
		TRAP        = 8'h12
	} opcode_t;

	typedef enum logic [3:0] {
		PASS_IMM, ADD, SUB, AND, OR, XOR, PASS_Y, ADDW, NONE
	} alu_op_t;

	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_ALWAYS, BR_Z, BR_NZ, BR_C
	} branch_t;

endpackage

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
	input logic clk,
	input logic reset,
	output logic [`CPU_DATA_W-1:0] iread_addr,
	input logic [`CPU_INSN_W-1:0] iread_data,
	output logic [`CPU_DATA_W-1:0] dwrite_addr,
	output logic [`CPU_DATA_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	logic [`CPU_DATA_W-1:0] x;
	logic [`CPU_DATA_W-1:0] y;
	logic [`CPU_DATA_W-1:0] z;
	cpu_pkg::flags_t flags;

	decode_if dec ();
	exec_result_if res ();

	insn_decode i_insn_decode (
		.insn (iread_data),
		.dec  (dec.decoder)
	);

	alu_exec i_alu_exec (
		.reset (reset),
		.dec   (dec.execute),
		.x     (x),
		.y     (y),
		.z     (z),
		.flags (flags),
		.res   (res.execute)
	);

	reg_writeback i_reg_writeback (
		.clk         (clk),
		.reset       (reset),
		.res         (res.writeback),
		.x           (x),
		.y           (y),
		.z           (z),
		.flags       (flags),
		.dwrite_addr (dwrite_addr),
		.dwrite_data (dwrite_data),
		.dwrite_en   (dwrite_en)
	);

	// fetch address is the pc itself
	pc_sequencer i_pc_sequencer (
		.clk   (clk),
		.reset (reset),
		.dec   (dec.sequencer),
		.flags (flags),
		.pc    (iread_addr),
		.trap  (trap)
	);
endmodule

// ==== hw/insn_decode.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module insn_decode (
	input logic [`CPU_INSN_W-1:0] insn,
	decode_if.decoder dec
);
	cpu_pkg::opcode_t opcode;

	assign opcode = cpu_pkg::opcode_t'(insn[7:0]);
	// bytes 1 and 2, little-endian
	assign dec.imm = insn[23:8];

	always_comb
	begin
		dec.alu_op = cpu_pkg::NONE;
		dec.dst = cpu_pkg::REG_X;
		dec.wr_en = 2'b00;
		dec.flag_upd = '0;
		dec.branch = cpu_pkg::BR_NONE;
		dec.length = 2'd1;
		dec.store_en = 2'b00;
		dec.halt = 1'b0;

		case (opcode)
			cpu_pkg::LD_XL_IMMD:
			begin
				dec.alu_op = cpu_pkg::PASS_IMM;
				dec.wr_en = 2'b01;
				dec.length = 2'd2;
			end
			cpu_pkg::ADD_XL_IMMD, cpu_pkg::SUB_XL_IMMD, cpu_pkg::CP_XL_IMMD:
			begin
				dec.alu_op = (opcode == cpu_pkg::ADD_XL_IMMD) ? cpu_pkg::ADD : cpu_pkg::SUB;
				// cp only sets flags
				dec.wr_en = (opcode == cpu_pkg::CP_XL_IMMD) ? 2'b00 : 2'b01;
				dec.flag_upd = '{c: 1'b1, z: 1'b1, n: 1'b1};
				dec.length = 2'd2;
			end
			cpu_pkg::AND_XL_IMMD, cpu_pkg::OR_XL_IMMD, cpu_pkg::XOR_XL_IMMD:
			begin
				dec.alu_op = (opcode == cpu_pkg::AND_XL_IMMD) ? cpu_pkg::AND :
					(opcode == cpu_pkg::OR_XL_IMMD) ? cpu_pkg::OR : cpu_pkg::XOR;
				dec.wr_en = 2'b01;
				// logic ops keep carry
				dec.flag_upd = '{c: 1'b0, z: 1'b1, n: 1'b1};
				dec.length = 2'd2;
			end
			cpu_pkg::LDW_Y_IMMD:
			begin
				dec.alu_op = cpu_pkg::PASS_IMM;
				dec.dst = cpu_pkg::REG_Y;
				dec.wr_en = 2'b11;
				dec.length = 2'd3;
			end
			cpu_pkg::LDW_X_Y, cpu_pkg::LDW_Z_Y:
			begin
				dec.alu_op = cpu_pkg::PASS_Y;
				dec.dst = (opcode == cpu_pkg::LDW_X_Y) ? cpu_pkg::REG_X : cpu_pkg::REG_Z;
				dec.wr_en = 2'b11;
			end
			cpu_pkg::ADDW_Y_X:
			begin
				dec.alu_op = cpu_pkg::ADDW;
				dec.dst = cpu_pkg::REG_Y;
				dec.wr_en = 2'b11;
				dec.flag_upd = '{c: 1'b1, z: 1'b1, n: 1'b1};
			end
			cpu_pkg::JR_D, cpu_pkg::JRZ_D, cpu_pkg::JRNZ_D, cpu_pkg::JRC_D:
			begin
				dec.branch = (opcode == cpu_pkg::JR_D) ? cpu_pkg::BR_ALWAYS :
					(opcode == cpu_pkg::JRZ_D) ? cpu_pkg::BR_Z :
					(opcode == cpu_pkg::JRNZ_D) ? cpu_pkg::BR_NZ : cpu_pkg::BR_C;
				dec.length = 2'd2;
			end
			cpu_pkg::LD_DIR_XL, cpu_pkg::LDW_DIR_Y:
			begin
				dec.store_en = (opcode == cpu_pkg::LD_DIR_XL) ? 2'b01 : 2'b11;
				dec.length = 2'd3;
			end
			cpu_pkg::TRAP:
				dec.halt = 1'b1;
			default:
				dec.alu_op = cpu_pkg::NONE;
		endcase
	end
endmodule

// ==== hw/pc_sequencer.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module pc_sequencer (
	input logic clk,
	input logic reset,
	decode_if.sequencer dec,
	input cpu_pkg::flags_t flags,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic trap
);
	logic taken;
	logic [`CPU_DATA_W-1:0] offset;

	always_comb
	begin
		case (dec.branch)
			cpu_pkg::BR_ALWAYS: taken = 1'b1;
			cpu_pkg::BR_Z: taken = flags.z;
			cpu_pkg::BR_NZ: taken = !flags.z;
			cpu_pkg::BR_C: taken = flags.c;
			default: taken = 1'b0;
		endcase
	end

	// signed displacement from the jump's own address
	assign offset = {{(`CPU_DATA_W-8){dec.imm[7]}}, dec.imm[7:0]};

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `CPU_RESET_PC;
		else if (taken)
			pc <= pc + offset;
		else if (!dec.halt)
			pc <= pc + {{(`CPU_DATA_W-2){1'b0}}, dec.length};
	end

	assign trap = dec.halt && !reset;
endmodule

// ==== hw/reg_writeback.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_writeback (
	input logic clk,
	input logic reset,
	exec_result_if.writeback res,
	output logic [`CPU_DATA_W-1:0] x,
	output logic [`CPU_DATA_W-1:0] y,
	output logic [`CPU_DATA_W-1:0] z,
	output cpu_pkg::flags_t flags,
	output logic [`CPU_DATA_W-1:0] dwrite_addr,
	output logic [`CPU_DATA_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en
);
	logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

	assign x = regs[cpu_pkg::REG_X];
	assign y = regs[cpu_pkg::REG_Y];
	assign z = regs[cpu_pkg::REG_Z];

	// per-byte write, strobes already masked in reset
	always_ff @(posedge clk)
	begin
		if (res.wr_en[0])
			regs[res.dst][7:0] <= res.result[7:0];
		if (res.wr_en[1])
			regs[res.dst][`CPU_DATA_W-1:8] <= res.result[`CPU_DATA_W-1:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= res.next_flags;
	end

	assign dwrite_addr = res.st_addr;
	assign dwrite_data = res.st_data;
	assign dwrite_en = res.st_en;
endmodule

// ==== project.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_ifs.sv
hw/insn_decode.sv
hw/alu_exec.sv
hw/reg_writeback.sv
hw/pc_sequencer.sv
hw/cpu_top.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module cpu_tb -f project.f \
	--Mdir obj_dir -o cpu_sim
./obj_dir/cpu_sim 2>&1 | tee sim.log
if grep -q "^STATUS: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== verification/cpu_chk.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_chk (
	input logic clk,
	input logic reset,
	input logic [`CPU_DATA_W-1:0] iread_addr,
	input logic [1:0] dwrite_en,
	input logic trap
);
	// nothing leaves the core while reset is high
	assert property (@(posedge clk) reset |-> dwrite_en == 2'b00)
		else $error("store strobe active during reset");

	// a halted core keeps fetching the same word
	assert property (@(posedge clk) disable iff (reset) trap |=> $stable(iread_addr))
		else $error("pc moved after trap");

	// none, low byte, or both bytes
	assert property (@(posedge clk) dwrite_en != 2'b10)
		else $error("illegal store strobe %b", dwrite_en);
endmodule

bind cpu_top cpu_chk i_cpu_chk (
	.clk        (clk),
	.reset      (reset),
	.iread_addr (iread_addr),
	.dwrite_en  (dwrite_en),
	.trap       (trap)
);

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;
	localparam int reset_cycles = 16;
	// six resets, the cycles of the five programs, and some slack
	localparam int budget = 6 * reset_cycles + 6 + 15 + 6 + 8 + 7 + 50;
	localparam logic [`CPU_DATA_W-1:0] start = `CPU_RESET_PC;

	logic clk;
	logic reset;
	logic [`CPU_DATA_W-1:0] iread_addr;
	logic [`CPU_INSN_W-1:0] iread_data;
	logic [`CPU_DATA_W-1:0] dwrite_addr;
	logic [`CPU_DATA_W-1:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;
	logic [7:0] prog [0:65535];
	int checks = 0;
	int errors = 0;
	int unsigned lcg_state = 81;

	cpu_top i_cpu_top (
		.clk         (clk),
		.reset       (reset),
		.iread_addr  (iread_addr),
		.iread_data  (iread_data),
		.dwrite_addr (dwrite_addr),
		.dwrite_data (dwrite_data),
		.dwrite_en   (dwrite_en),
		.trap        (trap)
	);

	// three bytes from the pc, little-endian
	assign iread_data = {prog[iread_addr + 16'd2], prog[iread_addr + 16'd1], prog[iread_addr]};

	always #5 clk = ~clk;

	function automatic logic [15:0] lcg_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic logic [7:0] byte_ref(input cpu_pkg::opcode_t op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			cpu_pkg::ADD_XL_IMMD: return a + b;
			cpu_pkg::SUB_XL_IMMD: return a - b;
			cpu_pkg::AND_XL_IMMD: return a & b;
			cpu_pkg::OR_XL_IMMD: return a | b;
			default: return a ^ b;
		endcase
	endfunction

	task automatic clear_prog();
		foreach (prog[i])
			prog[i] = 8'h00;
	endtask

	task automatic put_insn(input logic [15:0] at, input cpu_pkg::opcode_t op,
		input logic [15:0] imm, input int len);
		prog[at] = op;
		if (len > 1)
			prog[at + 16'd1] = imm[7:0];
		if (len > 2)
			prog[at + 16'd2] = imm[15:8];
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_pc(input logic [`CPU_DATA_W-1:0] expected);
		checks++;
		if (iread_addr !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: pc expected %h, got %h", $time, expected, iread_addr);
		end
	endtask

	task automatic check_trap(input logic expected);
		checks++;
		if (trap !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: trap expected %b, got %b", $time, expected, trap);
		end
	endtask

	task automatic check_store(input logic [1:0] en, input logic [`CPU_DATA_W-1:0] addr,
		input logic [`CPU_DATA_W-1:0] data);
		logic bad;
		checks++;
		bad = (dwrite_en !== en);
		if (en != 2'b00 && dwrite_addr !== addr)
			bad = 1'b1;
		if (en[0] && dwrite_data[7:0] !== data[7:0])
			bad = 1'b1;
		if (en[1] && dwrite_data[15:8] !== data[15:8])
			bad = 1'b1;
		if (bad)
		begin
			errors++;
			$display("MISMATCH at %0t ns: store expected %b %h=%h, got %b %h=%h", $time,
				en, addr, data, dwrite_en, dwrite_addr, dwrite_data);
		end
	endtask

	task automatic check_reg(input string name, input logic [`CPU_DATA_W-1:0] got,
		input logic [`CPU_DATA_W-1:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, got);
		end
	endtask

	// checks one instruction near the end of its cycle, then moves to the next one
	task automatic run_insn(input logic [`CPU_DATA_W-1:0] pc, input logic trap_exp = 1'b0,
		input logic [1:0] en = 2'b00, input logic [`CPU_DATA_W-1:0] addr = '0,
		input logic [`CPU_DATA_W-1:0] data = '0);
		#8;
		check_pc(pc);
		check_trap(trap_exp);
		check_store(en, addr, data);
		next_cycle();
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (reset_cycles)
		begin
			#8;
			check_store(2'b00, '0, '0);
			check_trap(1'b0);
			next_cycle();
		end
		reset = 1'b0;
	endtask

	task automatic test_pc_step();
		clear_prog();
		put_insn(start + 16'd2, cpu_pkg::LD_XL_IMMD, 16'h0012, 2);
		put_insn(start + 16'd4, cpu_pkg::LDW_Y_IMMD, 16'h1234, 3);
		put_insn(start + 16'd7, cpu_pkg::LD_DIR_XL, 16'h8000, 3);
		apply_reset();
		run_insn(start);
		run_insn(start + 16'd1);
		run_insn(start + 16'd2);
		run_insn(start + 16'd4);
		run_insn(start + 16'd7, 1'b0, 2'b01, 16'h8000, 16'h0012);
		run_insn(start + 16'd10);
	endtask

	task automatic test_byte_alu();
		logic [15:0] w;
		logic [15:0] at;
		logic [7:0] expect_byte [5];
		cpu_pkg::opcode_t op;
		clear_prog();
		at = start;
		for (int r = 0; r < 5; r++)
		begin
			w = lcg_rand();
			// add, sub, and, or and xor in turn
			op = cpu_pkg::opcode_t'(8'(r + 2));
			expect_byte[r] = byte_ref(op, w[7:0], w[15:8]);
			put_insn(at, cpu_pkg::LD_XL_IMMD, {8'h00, w[7:0]}, 2);
			put_insn(at + 16'd2, op, {8'h00, w[15:8]}, 2);
			put_insn(at + 16'd4, cpu_pkg::LD_DIR_XL, 16'h8100 + 16'(r), 3);
			at = at + 16'd7;
		end
		apply_reset();
		at = start;
		for (int r = 0; r < 5; r++)
		begin
			run_insn(at);
			run_insn(at + 16'd2);
			run_insn(at + 16'd4, 1'b0, 2'b01, 16'h8100 + 16'(r), {8'h00, expect_byte[r]});
			at = at + 16'd7;
		end
	endtask

	task automatic test_word_path();
		logic [15:0] w;
		logic [15:0] sum;
		clear_prog();
		w = lcg_rand();
		sum = w + w;
		put_insn(start, cpu_pkg::LDW_Y_IMMD, w, 3);
		put_insn(start + 16'd3, cpu_pkg::LDW_X_Y, 16'h0000, 1);
		put_insn(start + 16'd4, cpu_pkg::ADDW_Y_X, 16'h0000, 1);
		put_insn(start + 16'd5, cpu_pkg::LDW_DIR_Y, 16'h8200, 3);
		put_insn(start + 16'd8, cpu_pkg::LDW_Z_Y, 16'h0000, 1);
		apply_reset();
		run_insn(start);
		run_insn(start + 16'd3);
		run_insn(start + 16'd4);
		run_insn(start + 16'd5, 1'b0, 2'b11, 16'h8200, sum);
		run_insn(start + 16'd8);
		check_reg("z", i_cpu_top.z, sum);
		run_insn(start + 16'd9);
	endtask

	task automatic test_branches();
		clear_prog();
		put_insn(start, cpu_pkg::LD_XL_IMMD, 16'h005a, 2);
		put_insn(start + 16'd2, cpu_pkg::CP_XL_IMMD, 16'h005a, 2);
		put_insn(start + 16'd4, cpu_pkg::JRZ_D, 16'h0006, 2);
		// reached only by the backward jump
		put_insn(start + 16'd6, cpu_pkg::LD_DIR_XL, 16'h9000, 3);
		put_insn(start + 16'd9, cpu_pkg::TRAP, 16'h0000, 1);
		put_insn(start + 16'd10, cpu_pkg::JRNZ_D, 16'h0010, 2);
		put_insn(start + 16'd12, cpu_pkg::SUB_XL_IMMD, 16'h0080, 2);
		put_insn(start + 16'd14, cpu_pkg::JRC_D, 16'h00f8, 2);
		apply_reset();
		run_insn(start);
		run_insn(start + 16'd2);
		run_insn(start + 16'd4);
		// jrz lands 6 past its own address
		run_insn(start + 16'd10);
		run_insn(start + 16'd12);
		run_insn(start + 16'd14);
		// jrc goes 8 back to the store
		run_insn(start + 16'd6, 1'b0, 2'b01, 16'h9000, {8'h00, 8'h5a - 8'h80});
		run_insn(start + 16'd9, 1'b1);
	endtask

	task automatic test_trap_reset();
		clear_prog();
		put_insn(start + 16'd1, cpu_pkg::TRAP, 16'h0000, 1);
		apply_reset();
		run_insn(start);
		repeat (4)
			run_insn(start + 16'd1, 1'b1);
		apply_reset();
		run_insn(start);
		run_insn(start + 16'd1, 1'b1);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		test_pc_step();
		test_byte_alu();
		test_word_path();
		test_branches();
		test_trap_reset();
		$display("run complete: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		#(10 * budget);
		$display("timeout: the tests did not finish within %0d cycles", budget);
		$display("STATUS: FAIL");
		$finish;
	end
endmodule
